/* hdl/fc_eu_pkg.sv */
// Event unit package with sizing, APB register map and the bus structs
`default_nettype none

package fc_eu_pkg;

    // ****************************************
    // Sizing
    // ****************************************
    localparam int unsigned N_IRQ          = 32;
    localparam int unsigned IRQ_ID_W       = 5;
    localparam int unsigned EVT_ID_W       = 8;
    localparam int unsigned EVT_FIFO_DEPTH = 4;

    // Interrupt line raised while the event FIFO holds an entry
    localparam int unsigned FIFO_IRQ_ID    = 26;

    // ****************************************
    // APB register offsets
    // ****************************************
    localparam logic [11:0] REG_MASK     = 12'h000;
    localparam logic [11:0] REG_MASK_SET = 12'h004;
    localparam logic [11:0] REG_MASK_CLR = 12'h008;
    localparam logic [11:0] REG_INT      = 12'h00C;
    localparam logic [11:0] REG_INT_SET  = 12'h010;
    localparam logic [11:0] REG_INT_CLR  = 12'h014;
    localparam logic [11:0] REG_EVT_ID   = 12'h018;
    localparam logic [11:0] REG_CTRL     = 12'h01C;

    // ****************************************
    // Bus structs
    // ****************************************
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Request towards the core and its acknowledge back
    typedef struct packed {
        logic                req;
        logic [IRQ_ID_W-1:0] id;
    } irq_req_t;

    typedef struct packed {
        logic                ack;
        logic [IRQ_ID_W-1:0] id;
    } irq_ack_t;

    // Single-cycle software set and clear vectors
    typedef struct packed {
        logic [N_IRQ-1:0] set;
        logic [N_IRQ-1:0] clr;
    } sw_irq_t;

endpackage

`default_nettype wire

/* hdl/event_fifo.sv */
// Synchronous circular FIFO with a type-parameter payload, used for event IDs
`default_nettype none

module event_fifo import fc_eu_pkg::*; #(
    parameter type         payload_t = logic [EVT_ID_W-1:0],
    parameter int unsigned DEPTH     = EVT_FIFO_DEPTH
) (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     pop_i,
    output payload_t      data_o,
    output logic          empty_o,
    output logic          fulln_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             fulln_q;
    logic             push_ok;
    logic             pop_ok;

    // Wrap at DEPTH so that non power-of-two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ok = push_i & fulln_q;
    assign pop_ok  = pop_i & (count_q != '0);

    always_comb begin
        count_d = count_q;
        if (push_ok && !pop_ok) begin
            count_d = count_q + 1'b1;
        end else if (pop_ok && !push_ok) begin
            count_d = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            fulln_q  <= 1'b0;
        end else begin
            if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_ok)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_d;
            fulln_q <= (count_d != CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) mem_q[wr_ptr_q] <= data_i;
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign fulln_o = fulln_q;

endmodule

`default_nettype wire

/* hdl/irq_pending.sv */
// Interrupt pending register fed by event lines, software and the event FIFO
`default_nettype none

module irq_pending import fc_eu_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic [N_IRQ-1:0] events_i,
    input  wire sw_irq_t          sw_i,
    input  wire irq_ack_t         ack_i,
    input  wire logic             fifo_empty_i,
    output logic                  fifo_pop_o,
    output logic [N_IRQ-1:0]      pending_o
);

    logic [N_IRQ-1:0] pending_q;
    logic [N_IRQ-1:0] ack_vec;
    logic [N_IRQ-1:0] fifo_bit;
    logic [N_IRQ-1:0] set_vec;
    logic [N_IRQ-1:0] clr_vec;

    always_comb begin
        ack_vec  = '0;
        fifo_bit = '0;
        fifo_bit[FIFO_IRQ_ID] = 1'b1;
        if (ack_i.ack) begin
            ack_vec[ack_i.id] = 1'b1;
        end
    end

    assign set_vec = events_i | sw_i.set;
    assign clr_vec = sw_i.clr | ack_vec;

    // Acknowledging the FIFO line consumes the head entry instead of a bit
    assign fifo_pop_o = ack_i.ack && (ack_i.id == IRQ_ID_W'(FIFO_IRQ_ID));

    // Set beats clear on the same bit; the FIFO line is never stored here
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= ((pending_q & ~clr_vec) | set_vec) & ~fifo_bit;
        end
    end

    // FIFO line tracks the not-empty level directly
    assign pending_o = pending_q | (fifo_empty_i ? '0 : fifo_bit);

endmodule

`default_nettype wire

/* hdl/irq_arbiter.sv */
// Registered fixed-priority select of the highest masked pending interrupt
`default_nettype none

module irq_arbiter import fc_eu_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic [N_IRQ-1:0] pending_i,
    input  wire logic [N_IRQ-1:0] mask_i,
    output logic [IRQ_ID_W-1:0]   id_o,
    output logic                  valid_o
);

    logic [N_IRQ-1:0]    masked;
    logic [IRQ_ID_W-1:0] win_id;
    logic                win_valid;

    assign masked = pending_i & mask_i;

    // Ascending scan, so the last hit is the highest line
    always_comb begin
        win_id    = '0;
        win_valid = 1'b0;
        for (int i = 0; i < N_IRQ; i++) begin
            if (masked[i]) begin
                win_id    = IRQ_ID_W'(i);
                win_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_o    <= '0;
            valid_o <= 1'b0;
        end else begin
            id_o    <= win_id;
            valid_o <= win_valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/apb_eu_regs.sv */
// APB slave holding the event unit mask, control bits and software interrupt strobes
`default_nettype none

module apb_eu_regs import fc_eu_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire apb_req_t            apb_i,
    output apb_rsp_t                 apb_o,
    input  wire logic [N_IRQ-1:0]    pending_i,
    input  wire logic [EVT_ID_W-1:0] evt_id_i,
    output logic [N_IRQ-1:0]         mask_o,
    output sw_irq_t                  sw_o,
    output logic                     fetch_en_o,
    output logic                     sleep_o,
    input  wire logic                wake_i
);

    logic             access;
    logic             wr_en;
    logic             addr_ok;
    logic [31:0]      rdata;
    logic [N_IRQ-1:0] mask_q;
    logic             fetch_en_q;
    logic             sleep_q;

    // Access phase, no wait states
    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite;

    // ****************************************
    // Read mux and address decode
    // ****************************************
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (apb_i.paddr)
            REG_MASK, REG_MASK_SET, REG_MASK_CLR: begin
                rdata = mask_q;
            end
            REG_INT, REG_INT_SET, REG_INT_CLR: begin
                rdata = pending_i;
            end
            REG_EVT_ID: begin
                rdata = 32'(evt_id_i);
            end
            REG_CTRL: begin
                rdata = {30'b0, sleep_q, fetch_en_q};
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    assign apb_o.prdata  = rdata;
    assign apb_o.pready  = access;
    assign apb_o.pslverr = access & ~addr_ok;

    // Software set/clear strobes last only for the access cycle
    always_comb begin
        sw_o = '0;
        if (wr_en && (apb_i.paddr == REG_INT_SET)) begin
            sw_o.set = apb_i.pwdata;
        end
        if (wr_en && (apb_i.paddr == REG_INT_CLR)) begin
            sw_o.clr = apb_i.pwdata;
        end
    end

    // ****************************************
    // Mask and control state
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q     <= '0;
            fetch_en_q <= 1'b0;
            sleep_q    <= 1'b0;
        end else begin
            // Wake from the control block drops the sleep request
            if (wake_i) sleep_q <= 1'b0;
            if (wr_en) begin
                case (apb_i.paddr)
                    REG_MASK:     mask_q <= apb_i.pwdata;
                    REG_MASK_SET: mask_q <= mask_q | apb_i.pwdata;
                    REG_MASK_CLR: mask_q <= mask_q & ~apb_i.pwdata;
                    REG_CTRL: begin
                        fetch_en_q <= apb_i.pwdata[0];
                        sleep_q    <= apb_i.pwdata[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign mask_o     = mask_q;
    assign fetch_en_o = fetch_en_q;
    assign sleep_o    = sleep_q;

endmodule

`default_nettype wire

/* hdl/eu_ctrl.sv */
// Interrupt request/acknowledge sequencer with sleep clock gating and fetch enable
`default_nettype none

module eu_ctrl import fc_eu_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic [IRQ_ID_W-1:0] win_id_i,
    input  wire logic                win_valid_i,
    input  wire irq_ack_t            ack_i,
    input  wire logic                sleep_i,
    input  wire logic                fetch_en_reg_i,
    input  wire logic                fetch_en_i,
    output irq_req_t                 irq_o,
    output logic                     core_clock_en_o,
    output logic                     fetch_en_o,
    output logic                     wake_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        HOLDOFF
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [IRQ_ID_W-1:0] id_q;
    logic                hold_q;

    // ****************************************
    // Request FSM
    // ****************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // The core may ack in the very cycle the request appears
                if (win_valid_i) state_d = ack_i.ack ? HOLDOFF : REQ;
            end
            REQ: begin
                if (ack_i.ack) state_d = HOLDOFF;
            end
            HOLDOFF: begin
                // Two cycles, long enough for the cleared bit to leave the arbiter
                if (hold_q) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            hold_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            hold_q  <= (state_q == HOLDOFF) ? ~hold_q : 1'b0;
        end
    end

    // Winner captured when the request opens, held until ack
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) id_q <= win_id_i;
    end

    assign irq_o.req = (state_q == REQ) | ((state_q == IDLE) & win_valid_i);
    assign irq_o.id  = (state_q == IDLE) ? win_id_i : id_q;

    // Sleep gating, released by the first valid masked interrupt
    assign core_clock_en_o = ~sleep_i | win_valid_i;
    assign wake_o          = sleep_i & win_valid_i;
    assign fetch_en_o      = fetch_en_reg_i & fetch_en_i;

endmodule

`default_nettype wire

/* hdl/fc_subsystem.sv */
// Fabric controller top level around the event unit, core side exposed as ports
`default_nettype none

module fc_subsystem import fc_eu_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                fetch_en_i,

    // Direct interrupt lines and peripheral event stream
    input  wire logic [N_IRQ-1:0]    events_i,
    input  wire logic                event_fifo_valid_i,
    input  wire logic [EVT_ID_W-1:0] event_fifo_data_i,
    output logic                     event_fifo_fulln_o,

    // Register port
    input  wire apb_req_t            apb_i,
    output apb_rsp_t                 apb_o,

    // Core interrupt interface
    output irq_req_t                 irq_o,
    input  wire irq_ack_t            irq_ack_i,
    output logic                     core_clock_en_o,
    output logic                     fetch_en_o
);

    // FIFO to pending and register block
    logic                fifo_empty;
    logic                fifo_pop;
    logic [EVT_ID_W-1:0] fifo_head;

    // Pending, mask and winner
    logic [N_IRQ-1:0]    pending;
    logic [N_IRQ-1:0]    mask;
    sw_irq_t             sw_irq;
    logic [IRQ_ID_W-1:0] win_id;
    logic                win_valid;

    // Control bits
    logic                fetch_en_reg;
    logic                sleep;
    logic                wake;

    // ****************************************
    // Event unit datapath
    // ****************************************
    event_fifo #(
        .payload_t ( logic [EVT_ID_W-1:0] ),
        .DEPTH     ( EVT_FIFO_DEPTH       )
    ) u_event_fifo (
        .clk_i   ( clk_i              ),
        .rst_i   ( rst_i              ),
        .push_i  ( event_fifo_valid_i ),
        .data_i  ( event_fifo_data_i  ),
        .pop_i   ( fifo_pop           ),
        .data_o  ( fifo_head          ),
        .empty_o ( fifo_empty         ),
        .fulln_o ( event_fifo_fulln_o )
    );

    irq_pending u_irq_pending (
        .clk_i        ( clk_i      ),
        .rst_i        ( rst_i      ),
        .events_i     ( events_i   ),
        .sw_i         ( sw_irq     ),
        .ack_i        ( irq_ack_i  ),
        .fifo_empty_i ( fifo_empty ),
        .fifo_pop_o   ( fifo_pop   ),
        .pending_o    ( pending    )
    );

    irq_arbiter u_irq_arbiter (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .pending_i ( pending   ),
        .mask_i    ( mask      ),
        .id_o      ( win_id    ),
        .valid_o   ( win_valid )
    );

    // ****************************************
    // Registers and core sequencing
    // ****************************************
    apb_eu_regs u_apb_eu_regs (
        .clk_i      ( clk_i        ),
        .rst_i      ( rst_i        ),
        .apb_i      ( apb_i        ),
        .apb_o      ( apb_o        ),
        .pending_i  ( pending      ),
        .evt_id_i   ( fifo_head    ),
        .mask_o     ( mask         ),
        .sw_o       ( sw_irq       ),
        .fetch_en_o ( fetch_en_reg ),
        .sleep_o    ( sleep        ),
        .wake_i     ( wake         )
    );

    eu_ctrl u_eu_ctrl (
        .clk_i           ( clk_i           ),
        .rst_i           ( rst_i           ),
        .win_id_i        ( win_id          ),
        .win_valid_i     ( win_valid       ),
        .ack_i           ( irq_ack_i       ),
        .sleep_i         ( sleep           ),
        .fetch_en_reg_i  ( fetch_en_reg    ),
        .fetch_en_i      ( fetch_en_i      ),
        .irq_o           ( irq_o           ),
        .core_clock_en_o ( core_clock_en_o ),
        .fetch_en_o      ( fetch_en_o      ),
        .wake_o          ( wake            )
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset source with a 10 unit period and a 10 cycle reset
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release just after an edge, like every other testbench input
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tb_fc_subsystem.sv */
// Testbench for the fabric controller event unit with a core model and reference winner
`default_nettype none

module tb_fc_subsystem import fc_eu_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                clk;
    logic                rst;
    logic                fetch_en;
    logic [N_IRQ-1:0]    events;
    logic                fifo_valid;
    logic [EVT_ID_W-1:0] fifo_data;
    logic                fifo_fulln;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    irq_req_t            irq_req;
    irq_ack_t            irq_ack;
    logic                core_clock_en;
    logic                fetch_en_out;

    // Reference model state
    logic [N_IRQ-1:0]    model_pend = '0;
    logic [N_IRQ-1:0]    model_mask = '0;
    logic [EVT_ID_W-1:0] fifo_q[$];
    integer              seed = 32'h2fa2b2ec;
    string               test_name = "reset";
    logic                auto_ack = 1'b1;
    int unsigned         cycle_cnt = 0;
    int unsigned         req_cnt = 0;
    logic                mon_req_q = 1'b0;
    logic                mon_ack_q = 1'b0;
    logic [IRQ_ID_W-1:0] mon_id_q = '0;

    tb_clk_gen u_clk_gen (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    fc_subsystem dut_i (
        .clk_i              ( clk           ),
        .rst_i              ( rst           ),
        .fetch_en_i         ( fetch_en      ),
        .events_i           ( events        ),
        .event_fifo_valid_i ( fifo_valid    ),
        .event_fifo_data_i  ( fifo_data     ),
        .event_fifo_fulln_o ( fifo_fulln    ),
        .apb_i              ( apb_req       ),
        .apb_o              ( apb_rsp       ),
        .irq_o              ( irq_req       ),
        .irq_ack_i          ( irq_ack       ),
        .core_clock_en_o    ( core_clock_en ),
        .fetch_en_o         ( fetch_en_out  )
    );

    // ****************************************
    // Reference model and checking
    // ****************************************
    function automatic logic [IRQ_ID_W-1:0] ref_winner(input logic [N_IRQ-1:0] pend,
                                                       input logic [N_IRQ-1:0] mask);
        logic [N_IRQ-1:0]    hits;
        logic [IRQ_ID_W-1:0] id;
        hits = pend & mask;
        id   = '0;
        for (int i = int'(N_IRQ) - 1; i >= 0; i--) begin
            if (hits[i]) begin
                id = IRQ_ID_W'(i);
                break;
            end
        end
        return id;
    endfunction

    // FIFO line is the not-empty state of the queued IDs
    function automatic logic [N_IRQ-1:0] model_pending();
        logic [N_IRQ-1:0] pend;
        pend = model_pend;
        pend[FIFO_IRQ_ID] = (fifo_q.size() != 0);
        return pend;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error: %s (%s) expected %h actual %h", test_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_drive();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        wait_drive();
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        wait_drive();
        apb_req.penable = 1'b1;
        @(negedge clk);
        check("pready", 32'd1, 32'(apb_rsp.pready));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        wait_drive();
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check("write pslverr", 32'd0, 32'(err));
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check("read pslverr", 32'd0, 32'(err));
    endtask

    // One cycle acknowledge that also drops the bit or the FIFO head from the model
    task automatic ack_irq(input logic [IRQ_ID_W-1:0] id);
        wait_drive();
        irq_ack.ack = 1'b1;
        irq_ack.id  = id;
        if (id == IRQ_ID_W'(FIFO_IRQ_ID)) begin
            void'(fifo_q.pop_front());
        end else begin
            model_pend[id] = 1'b0;
        end
        wait_drive();
        irq_ack = '0;
    endtask

    task automatic wait_drain();
        while ((model_pending() & model_mask) != '0) wait_drive();
        repeat (4) wait_drive();
        check("req idle after drain", 32'd0, 32'(irq_req.req));
    endtask

    // Compare each new request with the model and watch that it holds until ack
    always @(negedge clk) begin
        if (irq_req.req === 1'b1 && !mon_req_q) begin
            check("winner id", 32'(ref_winner(model_pending(), model_mask)), 32'(irq_req.id));
            req_cnt = req_cnt + 1;
        end
        if (mon_req_q && !mon_ack_q) begin
            check("req held", 32'd1, 32'(irq_req.req));
            check("id held", 32'(mon_id_q), 32'(irq_req.id));
        end
        mon_req_q = (irq_req.req === 1'b1);
        mon_ack_q = (irq_ack.ack === 1'b1);
        mon_id_q  = irq_req.id;
    end

    // Core model that acks after a random delay
    initial begin : core_responder
        int                  dly;
        logic [IRQ_ID_W-1:0] id;
        forever begin
            @(negedge clk);
            if (auto_ack && irq_req.req === 1'b1) begin
                id  = irq_req.id;
                dly = int'($unsigned($random(seed)) % 4);
                repeat (dly) @(posedge clk);
                ack_irq(id);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles during %s", TIMEOUT_CYCLES, test_name);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ****************************************
    // Stimulus
    // ****************************************
    initial begin : main_seq
        logic [31:0] rd;
        logic [31:0] wd;
        logic        err;
        int          op;
        int          lo;
        int          hi;
        int unsigned cnt0;

        fetch_en   = 1'b1;
        events     = '0;
        fifo_valid = 1'b0;
        fifo_data  = '0;
        apb_req    = '0;
        irq_ack    = '0;

        @(negedge rst);
        @(negedge clk);
        check("req after reset", 32'd0, 32'(irq_req.req));
        check("fetch after reset", 32'd0, 32'(fetch_en_out));
        check("fulln before first edge", 32'd0, 32'(fifo_fulln));
        check("clock enable after reset", 32'd1, 32'(core_clock_en));
        @(negedge clk);
        check("fulln after first edge", 32'd1, 32'(fifo_fulln));

        test_name = "register access";
        apb_read(REG_MASK, rd);
        check("mask after reset", 32'd0, rd);
        apb_read(REG_CTRL, rd);
        check("ctrl after reset", 32'd0, rd);
        for (int i = 0; i < 12; i++) begin
            op = int'($unsigned($random(seed)) % 3);
            wd = $random(seed);
            if (op == 0) begin
                apb_write(REG_MASK, wd);
                model_mask = wd;
            end else if (op == 1) begin
                apb_write(REG_MASK_SET, wd);
                model_mask = model_mask | wd;
            end else begin
                apb_write(REG_MASK_CLR, wd);
                model_mask = model_mask & ~wd;
            end
            apb_read(REG_MASK, rd);
            check("mask readback", model_mask, rd);
        end
        apb_xfer(1'b0, 12'h020, '0, rd, err);
        check("unlisted read", 32'd1, 32'(err));
        apb_xfer(1'b1, 12'h002, $random(seed), rd, err);
        check("unlisted write", 32'd1, 32'(err));

        test_name = "priority";
        for (int r = 0; r < 6; r++) begin
            wd = $random(seed);
            apb_write(REG_MASK, wd);
            model_mask = wd;
            wait_drive();
            events = $random(seed);
            events[FIFO_IRQ_ID] = 1'b0;
            model_pend = model_pend | events;
            wait_drive();
            events = '0;
            wait_drain();
            apb_read(REG_INT, rd);
            check("unmasked pending", model_pending(), rd);
            apb_write(REG_INT_CLR, model_pend);
            model_pend = '0;
        end

        test_name = "software interrupts";
        apb_write(REG_MASK, '0);
        model_mask = '0;
        lo   = int'($unsigned($random(seed)) % 16);
        hi   = 16 + int'($unsigned($random(seed)) % 8);
        cnt0 = req_cnt;
        apb_write(REG_INT_SET, (32'd1 << lo) | (32'd1 << hi));
        model_pend = model_pend | (32'd1 << lo) | (32'd1 << hi);
        apb_write(REG_INT_CLR, 32'd1 << hi);
        model_pend = model_pend & ~(32'd1 << hi);
        apb_write(REG_MASK, '1);
        model_mask = '1;
        wait_drain();
        apb_write(REG_INT_SET, 32'd1 << hi);
        model_pend = model_pend | (32'd1 << hi);
        wait_drain();
        check("software request count", 32'(cnt0 + 2), 32'(req_cnt));
        apb_read(REG_INT, rd);
        check("pending after drain", 32'd0, rd);

        test_name = "event fifo";
        apb_write(REG_MASK, 32'd1 << FIFO_IRQ_ID);
        model_mask = 32'd1 << FIFO_IRQ_ID;
        auto_ack = 1'b0;
        while (fifo_fulln) begin
            fifo_valid = 1'b1;
            fifo_data  = EVT_ID_W'($random(seed));
            fifo_q.push_back(fifo_data);
            wait_drive();
        end
        // This push meets a full FIFO and must be dropped
        fifo_data = EVT_ID_W'($random(seed));
        wait_drive();
        fifo_valid = 1'b0;
        check("fifo fill level", 32'(EVT_FIFO_DEPTH), 32'(fifo_q.size()));
        for (int i = 0; i < int'(EVT_FIFO_DEPTH); i++) begin
            while (irq_req.req !== 1'b1) wait_drive();
            apb_read(REG_EVT_ID, rd);
            check("event id order", 32'(fifo_q[0]), rd);
            ack_irq(irq_req.id);
        end
        repeat (4) wait_drive();
        check("req after fifo drain", 32'd0, 32'(irq_req.req));
        check("fulln after drain", 32'd1, 32'(fifo_fulln));
        apb_read(REG_INT, rd);
        check("fifo line after drain", 32'd0, rd);
        auto_ack = 1'b1;

        test_name = "sleep";
        lo = int'($unsigned($random(seed)) % 16);
        apb_write(REG_MASK, 32'd1 << lo);
        model_mask = 32'd1 << lo;
        apb_write(REG_CTRL, 32'h3);
        repeat (3) begin
            wait_drive();
            check("clock gated", 32'd0, 32'(core_clock_en));
        end
        events = 32'd1 << lo;
        model_pend = model_pend | events;
        wait_drive();
        events = '0;
        while (!core_clock_en) wait_drive();
        wait_drain();
        check("clock enable after wake", 32'd1, 32'(core_clock_en));
        apb_read(REG_CTRL, rd);
        check("ctrl after wake", 32'h1, rd);

        test_name = "fetch enable";
        for (int k = 0; k < 4; k++) begin
            apb_write(REG_CTRL, 32'(k & 1));
            fetch_en = (k >= 2);
            wait_drive();
            check("fetch_en_o", 32'((k & 1) != 0 && k >= 2), 32'(fetch_en_out));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/fc_eu_pkg.sv
hdl/event_fifo.sv
hdl/irq_pending.sv
hdl/irq_arbiter.sv
hdl/apb_eu_regs.sv
hdl/eu_ctrl.sv
hdl/fc_subsystem.sv
testbench/tb_clk_gen.sv
testbench/tb_fc_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the event unit testbench with Verilator

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_fc_subsystem -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
